// ==== apb_periph_decoder.sv ====
// apb region decoder, one select per peripheral and response mux with unmapped error
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module apb_periph_decoder import soc_periph_pkg::*; (
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,

    output apb_req_t gpio_req_o,
    input  apb_rsp_t gpio_rsp_i,
    output apb_req_t timer_req_o,
    input  apb_rsp_t timer_rsp_i,
    output apb_req_t evtgen_req_o,
    input  apb_rsp_t evtgen_rsp_i
);

    logic [`SOC_APB_ADDR_W-`SOC_REGION_LSB-1:0] region_field;
    periph_region_e                             region;

    assign region_field = apb_req_i.paddr[`SOC_APB_ADDR_W-1:`SOC_REGION_LSB];

    always_comb begin
        case (region_field)
            GPIO:    region = GPIO;
            TIMER:   region = TIMER;
            EVTGEN:  region = EVTGEN;
            default: region = NONE;     // holes in the map
        endcase
    end

    // same request everywhere, only the addressed block sees psel/penable
    always_comb begin
        gpio_req_o           = apb_req_i;
        timer_req_o          = apb_req_i;
        evtgen_req_o         = apb_req_i;
        gpio_req_o.psel      = apb_req_i.psel    && (region == GPIO);
        gpio_req_o.penable   = apb_req_i.penable && (region == GPIO);
        timer_req_o.psel     = apb_req_i.psel    && (region == TIMER);
        timer_req_o.penable  = apb_req_i.penable && (region == TIMER);
        evtgen_req_o.psel    = apb_req_i.psel    && (region == EVTGEN);
        evtgen_req_o.penable = apb_req_i.penable && (region == EVTGEN);
    end

    always_comb begin
        case (region)
            GPIO:    apb_rsp_o = gpio_rsp_i;
            TIMER:   apb_rsp_o = timer_rsp_i;
            EVTGEN:  apb_rsp_o = evtgen_rsp_i;
            default: begin
                apb_rsp_o.prdata  = '0;             // nobody home
                apb_rsp_o.pready  = 1'b1;
                apb_rsp_o.pslverr = apb_req_i.psel;
            end
        endcase
    end

    // master protocol, access phase only inside a selected transfer
    always_comb begin
        if (apb_req_i.penable) begin
            assert (apb_req_i.psel) else $error("apb penable without psel");
        end
    end

endmodule

// ==== periph_gpio.sv ====
// gpio bank with out/dir registers, synchronized inputs and rising-edge interrupts
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module periph_gpio import soc_periph_pkg::*; (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  apb_req_t                 apb_req_i,
    output apb_rsp_t                 apb_rsp_o,
    input  logic [`SOC_GPIO_NUM-1:0] gpio_in_i,
    output logic [`SOC_GPIO_NUM-1:0] gpio_out_o,
    output logic [`SOC_GPIO_NUM-1:0] gpio_dir_o,
    output logic                     gpio_evt_o
);

    localparam int N = `SOC_GPIO_NUM;

    logic [N-1:0]                 out_q, dir_q, irq_en_q, irq_status_q;
    logic [N-1:0]                 sync1_q, sync2_q, last_q;   // 2-flop sync + edge history
    logic [N-1:0]                 rise, status_clr;
    logic                         evt_q;
    logic                         wr_en, bad_offs;
    logic [`SOC_REGION_LSB-1:0]   offs;
    logic [`SOC_APB_DATA_W-1:0]   rdata;

    assign offs       = apb_req_i.paddr[`SOC_REGION_LSB-1:0];
    assign wr_en      = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
    assign rise       = sync2_q & ~last_q & irq_en_q;   // enabled pins only
    assign status_clr = (wr_en && offs == `SOC_GPIO_IRQ_STATUS) ? apb_req_i.pwdata[N-1:0] : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q      <= '0;
            sync2_q      <= '0;
            last_q       <= '0;
            out_q        <= '0;
            dir_q        <= '0;   // all inputs
            irq_en_q     <= '0;
            irq_status_q <= '0;
            evt_q        <= 1'b0;
        end else begin
            sync1_q      <= gpio_in_i;
            sync2_q      <= sync1_q;
            last_q       <= sync2_q;
            evt_q        <= |rise;                                  // 3rd edge after pin change
            irq_status_q <= (irq_status_q & ~status_clr) | rise;    // set beats clear
            if (wr_en) begin
                case (offs)
                    `SOC_GPIO_OUT:    out_q    <= apb_req_i.pwdata[N-1:0];
                    `SOC_GPIO_DIR:    dir_q    <= apb_req_i.pwdata[N-1:0];
                    `SOC_GPIO_IRQ_EN: irq_en_q <= apb_req_i.pwdata[N-1:0];
                    default: ;    // in/status handled above, rest ignored
                endcase
            end
        end
    end

    // read side, combinational in the access cycle
    always_comb begin
        rdata    = '0;
        bad_offs = 1'b0;
        case (offs)
            `SOC_GPIO_OUT:        rdata[N-1:0] = out_q;
            `SOC_GPIO_DIR:        rdata[N-1:0] = dir_q;
            `SOC_GPIO_IN:         rdata[N-1:0] = sync2_q;
            `SOC_GPIO_IRQ_EN:     rdata[N-1:0] = irq_en_q;
            `SOC_GPIO_IRQ_STATUS: rdata[N-1:0] = irq_status_q;
            default:              bad_offs     = 1'b1;
        endcase
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = apb_req_i.psel && bad_offs;

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign gpio_evt_o = evt_q;

endmodule

// ==== periph_ref_timer.sv ====
// reference timer counting synchronized slow clock ticks against a compare value
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module periph_ref_timer import soc_periph_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     slow_clk_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    output logic     timer_irq_o,
    output logic     ref_edge_evt_o
);

    logic                       sync1_q, sync2_q, last_q;
    logic                       rise, fall, tick, wrap;
    logic                       en_q, irq_status_q, irq_q, edge_q;
    logic [`SOC_APB_DATA_W-1:0] cnt_q, cmp_q;
    logic                       wr_en, cmp_wr, status_clr, bad_offs;
    logic [`SOC_REGION_LSB-1:0] offs;
    logic [`SOC_APB_DATA_W-1:0] rdata;

    assign offs       = apb_req_i.paddr[`SOC_REGION_LSB-1:0];
    assign wr_en      = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
    assign cmp_wr     = wr_en && offs == `SOC_TMR_CMP;
    assign status_clr = wr_en && offs == `SOC_TMR_IRQ_STATUS && apb_req_i.pwdata[0];

    assign rise = sync2_q & ~last_q;
    assign fall = ~sync2_q & last_q;
    assign tick = en_q && rise;             // one tick per slow period
    assign wrap = tick && (cnt_q == cmp_q); // interval is compare+1 ticks

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q      <= 1'b0;
            sync2_q      <= 1'b0;
            last_q       <= 1'b0;
            edge_q       <= 1'b0;
            irq_q        <= 1'b0;
            irq_status_q <= 1'b0;
            en_q         <= 1'b0;
            cnt_q        <= '0;
            cmp_q        <= '0;
        end else begin
            sync1_q <= slow_clk_i;
            sync2_q <= sync1_q;
            last_q  <= sync2_q;
            edge_q  <= rise | fall;     // both edges of the ref clock
            irq_q   <= wrap;
            if (wrap)            irq_status_q <= 1'b1;
            else if (status_clr) irq_status_q <= 1'b0;
            if (wrap)            cnt_q <= '0;
            else if (tick)       cnt_q <= cnt_q + 1'b1;
            if (wr_en && offs == `SOC_TMR_CTRL) en_q <= apb_req_i.pwdata[0];
            if (cmp_wr)          cmp_q <= apb_req_i.pwdata;
        end
    end

    always_comb begin
        rdata    = '0;
        bad_offs = 1'b0;
        case (offs)
            `SOC_TMR_CTRL:       rdata[0] = en_q;
            `SOC_TMR_COUNT:      rdata    = cnt_q;
            `SOC_TMR_CMP:        rdata    = cmp_q;
            `SOC_TMR_IRQ_STATUS: rdata[0] = irq_status_q;
            default:             bad_offs = 1'b1;
        endcase
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = apb_req_i.psel && bad_offs;
    assign timer_irq_o       = irq_q;
    assign ref_edge_evt_o    = edge_q;

    // once below compare, the counter wraps before passing it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (en_q && cnt_q <= cmp_q && !cmp_wr) |=> (cnt_q <= cmp_q))
        else $error("timer count passed compare");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the soc peripheral testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_soc_periph -f soc_periph.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_soc_periph)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== soc_event_gen.sv ====
// soc event generator, masks peripheral events and queues their ids for the fc
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module soc_event_gen import soc_periph_pkg::*; (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  apb_req_t                     apb_req_i,
    output apb_rsp_t                     apb_rsp_o,
    input  logic [`SOC_PER_EVNT_NUM-1:0] per_events_i,
    output logic                         err_evt_o,
    output logic                         fc_event_valid_o,
    output logic [`SOC_EVNT_W-1:0]       fc_event_data_o,
    input  logic                         fc_event_ready_i
);

    localparam int N  = `SOC_PER_EVNT_NUM;
    localparam int EW = `SOC_EVNT_W;
    localparam int D  = `SOC_EVT_FIFO_DEPTH;
    localparam int PW = $clog2(D);

    logic [N-1:0]               mask_q, pending_q, err_status_q;
    logic [N-1:0]               fire, pick_oh, taken, err_hit, err_clr;
    logic [EW-1:0]              pick_id, push_data;
    logic [EW-1:0]              fifo_mem [D];
    logic [PW-1:0]              wr_ptr_q, rd_ptr_q;
    logic [PW:0]                cnt_q;
    logic                       full, push, pop, sw_push, pick_valid, err_q;
    logic                       wr_en, bad_offs;
    logic [`SOC_REGION_LSB-1:0] offs;
    logic [`SOC_APB_DATA_W-1:0] rdata;

    assign offs  = apb_req_i.paddr[`SOC_REGION_LSB-1:0];
    assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
    assign fire  = per_events_i & mask_q;

    // lowest pending index wins
    always_comb begin
        pick_oh = '0;
        pick_id = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                pick_oh    = '0;
                pick_oh[i] = 1'b1;
                pick_id    = EW'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // push side, sw write first, then one pending source per cycle
    //////////////////////////////////////////////////////////////////////
    assign full       = (cnt_q == D);
    assign sw_push    = wr_en && offs == `SOC_EVG_SW_EVENT && !full;   // dropped when full
    assign pick_valid = |pending_q && !full && !sw_push;
    assign push       = sw_push || pick_valid;
    assign push_data  = sw_push ? apb_req_i.pwdata[EW-1:0] : pick_id;
    assign taken      = pick_valid ? pick_oh : '0;
    assign err_hit    = fire & pending_q & ~taken;     // refire before it was queued
    assign err_clr    = (wr_en && offs == `SOC_EVG_ERR_STATUS) ? apb_req_i.pwdata[N-1:0] : '0;
    assign pop        = fc_event_valid_o && fc_event_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q       <= '0;
            pending_q    <= '0;
            err_status_q <= '0;
            err_q        <= 1'b0;
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            cnt_q        <= '0;
        end else begin
            pending_q    <= (pending_q & ~taken) | fire;
            err_status_q <= (err_status_q & ~err_clr) | err_hit;
            err_q        <= |err_hit;
            if (wr_en && offs == `SOC_EVG_MASK) mask_q <= apb_req_i.pwdata[N-1:0];
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;      // depth is a power of two
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) fifo_mem[wr_ptr_q] <= push_data;
    end

    always_comb begin
        rdata    = '0;
        bad_offs = 1'b0;
        case (offs)
            `SOC_EVG_MASK:       rdata[N-1:0] = mask_q;
            `SOC_EVG_SW_EVENT:   rdata        = '0;     // write only
            `SOC_EVG_ERR_STATUS: rdata[N-1:0] = err_status_q;
            default:             bad_offs     = 1'b1;
        endcase
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = apb_req_i.psel && bad_offs;
    assign err_evt_o         = err_q;
    assign fc_event_valid_o  = (cnt_q != '0);
    assign fc_event_data_o   = fifo_mem[rd_ptr_q];

    // occupancy stays within the depth, push into full or pop from empty breaks it
    assert property (@(posedge clk_i) disable iff (!arst_n_i) cnt_q <= D)
        else $error("event fifo overflow or underflow");
    // fc side may stall us for any number of cycles
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (fc_event_valid_o && !fc_event_ready_i) |=>
        (fc_event_valid_o && $stable(fc_event_data_o)))
        else $error("fc event dropped or changed under back-pressure");

endmodule

// ==== soc_periph.f ====
+incdir+.
soc_periph_pkg.sv
apb_periph_decoder.sv
periph_gpio.sv
periph_ref_timer.sv
soc_event_gen.sv
soc_periph_top.sv
tb_soc_periph.sv

// ==== soc_periph_macros.svh ====
// soc peripheral subsystem widths, address map, register offsets and fc event bits
`ifndef SOC_PERIPH_MACROS_SVH
`define SOC_PERIPH_MACROS_SVH

// apb port
`define SOC_APB_ADDR_W      12
`define SOC_APB_DATA_W      32
`define SOC_REGION_LSB      8       // region field is paddr[11:8]

// block sizes
`define SOC_GPIO_NUM        8
`define SOC_PER_EVNT_NUM    8
`define SOC_EVNT_W          8
`define SOC_EVT_FIFO_DEPTH  4
`define SOC_FC_EVT_NUM      32

// positions in fc_events_o
`define SOC_FC_BIT_TIMER    10
`define SOC_FC_BIT_REF      14
`define SOC_FC_BIT_GPIO     15
`define SOC_FC_BIT_ERR      29

// register offsets inside a region
`define SOC_GPIO_OUT        8'h00
`define SOC_GPIO_DIR        8'h04
`define SOC_GPIO_IN         8'h08   // read only
`define SOC_GPIO_IRQ_EN     8'h0C
`define SOC_GPIO_IRQ_STATUS 8'h10   // write 1 to clear
`define SOC_TMR_CTRL        8'h00   // bit 0 enable
`define SOC_TMR_COUNT       8'h04   // read only
`define SOC_TMR_CMP         8'h08
`define SOC_TMR_IRQ_STATUS  8'h0C
`define SOC_EVG_MASK        8'h00
`define SOC_EVG_SW_EVENT    8'h04   // pushes pwdata[7:0]
`define SOC_EVG_ERR_STATUS  8'h08

`endif

// ==== soc_periph_pkg.sv ====
// shared apb request/response structs and peripheral region codes
`include "soc_periph_macros.svh"

package soc_periph_pkg;

    ////////////////////////////////////////////////////////////////////
    // apb bus
    ////////////////////////////////////////////////////////////////////

    // master to slave, one transfer = setup cycle then access cycle
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`SOC_APB_ADDR_W-1:0] paddr;
        logic [`SOC_APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // slave to master, no wait states so pready stays high
    typedef struct packed {
        logic [`SOC_APB_DATA_W-1:0] prdata;
        logic                       pready;
        logic                       pslverr;
    } apb_rsp_t;

    ////////////////////////////////////////////////////////////////////
    // address map, paddr[11:8]
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [`SOC_APB_ADDR_W-`SOC_REGION_LSB-1:0] {
        GPIO   = 4'd0,
        TIMER  = 4'd1,
        EVTGEN = 4'd2,
        NONE   = 4'hF   // anything unmapped
    } periph_region_e;

endpackage

// ==== soc_periph_top.sv ====
// peripheral subsystem top, apb decode to gpio, ref timer and event generator
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module soc_periph_top import soc_periph_pkg::*; (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       slow_clk_i,
    input  apb_req_t                   apb_req_i,
    output apb_rsp_t                   apb_rsp_o,
    input  logic [`SOC_GPIO_NUM-1:0]   gpio_in_i,
    output logic [`SOC_GPIO_NUM-1:0]   gpio_out_o,
    output logic [`SOC_GPIO_NUM-1:0]   gpio_dir_o,
    input  logic [5:0]                 periph_evt_i,
    output logic [`SOC_FC_EVT_NUM-1:0] fc_events_o,
    output logic                       fc_event_valid_o,
    output logic [`SOC_EVNT_W-1:0]     fc_event_data_o,
    input  logic                       fc_event_ready_i
);

    apb_req_t gpio_req, timer_req, evtgen_req;
    apb_rsp_t gpio_rsp, timer_rsp, evtgen_rsp;

    logic                         gpio_evt, timer_irq, ref_edge_evt, err_evt;
    logic [`SOC_PER_EVNT_NUM-1:0] per_events;

    assign per_events = {timer_irq, gpio_evt, periph_evt_i};   // sources 7, 6, 5:0

    // fixed fc map, reserved bits stay zero
    always_comb begin
        fc_events_o                    = '0;
        fc_events_o[`SOC_FC_BIT_TIMER] = timer_irq;
        fc_events_o[`SOC_FC_BIT_REF]   = ref_edge_evt;
        fc_events_o[`SOC_FC_BIT_GPIO]  = gpio_evt;
        fc_events_o[`SOC_FC_BIT_ERR]   = err_evt;
    end

    //////////////////////////////////////////////////////////////////////
    // apb decode
    //////////////////////////////////////////////////////////////////////
    apb_periph_decoder u_decoder (
        .apb_req_i    ( apb_req_i  ),
        .apb_rsp_o    ( apb_rsp_o  ),
        .gpio_req_o   ( gpio_req   ),
        .gpio_rsp_i   ( gpio_rsp   ),
        .timer_req_o  ( timer_req  ),
        .timer_rsp_i  ( timer_rsp  ),
        .evtgen_req_o ( evtgen_req ),
        .evtgen_rsp_i ( evtgen_rsp )
    );

    //////////////////////////////////////////////////////////////////////
    // peripherals
    //////////////////////////////////////////////////////////////////////
    periph_gpio u_gpio (
        .clk_i      ( clk_i      ),
        .arst_n_i   ( arst_n_i   ),
        .apb_req_i  ( gpio_req   ),
        .apb_rsp_o  ( gpio_rsp   ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .gpio_evt_o ( gpio_evt   )
    );

    periph_ref_timer u_ref_timer (
        .clk_i          ( clk_i        ),
        .arst_n_i       ( arst_n_i     ),
        .slow_clk_i     ( slow_clk_i   ),
        .apb_req_i      ( timer_req    ),
        .apb_rsp_o      ( timer_rsp    ),
        .timer_irq_o    ( timer_irq    ),
        .ref_edge_evt_o ( ref_edge_evt )
    );

    soc_event_gen u_evnt_gen (
        .clk_i            ( clk_i            ),
        .arst_n_i         ( arst_n_i         ),
        .apb_req_i        ( evtgen_req       ),
        .apb_rsp_o        ( evtgen_rsp       ),
        .per_events_i     ( per_events       ),
        .err_evt_o        ( err_evt          ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  ),
        .fc_event_ready_i ( fc_event_ready_i )
    );

endmodule

// ==== soc_periph_trace.txt ====
# op and hex fields: W addr data | R addr data err | G pins | E events | Q ready
# P popped id | N fc_events bit count tolerance | Z clear pulse counts | C cycles
W 000 a5
W 004 3c
R 000 a5 0
R 004 3c 0
G 5a
C 4
R 008 5a 0
R 300 0 1
R 014 0 1
R 20c 0 1
W 300 ff
W 014 ff
R 000 a5 0
R 004 3c 0
G 00
C 4
Z
W 00c 04
G 04
C 6
R 010 04 0
N 0f 1 0
W 010 04
R 010 0 0
Z
G 0c
C 6
R 010 0 0
N 0f 0 0
W 108 3
W 100 1
Z
C a0
N 0a 5 1
N 0e 28 1
W 100 0
R 10c 1 0
W 200 49
Q 1
E 09
P 00
P 03
E 02
C 8
W 204 55
P 55
W 200 3f
Q 0
Z
E 1f
C 6
E 10
C 4
N 1d 1 0
R 208 10 0
Q 1
P 00
P 01
P 02
P 03
P 04
W 208 10
R 208 0 0

// ==== tb_soc_periph.sv ====
// testbench for the soc peripheral subsystem, replays a trace of apb, pin and event operations
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module tb_soc_periph import soc_periph_pkg::*; ();

    localparam logic [`SOC_APB_ADDR_W-1:0] GPIO_OUT_ADDR = {4'h0, `SOC_GPIO_OUT};
    localparam logic [`SOC_APB_ADDR_W-1:0] GPIO_DIR_ADDR = {4'h0, `SOC_GPIO_DIR};
    localparam logic [`SOC_FC_EVT_NUM-1:0] FC_USED_BITS  = (32'd1 << `SOC_FC_BIT_TIMER)
                                                         | (32'd1 << `SOC_FC_BIT_REF)
                                                         | (32'd1 << `SOC_FC_BIT_GPIO)
                                                         | (32'd1 << `SOC_FC_BIT_ERR);

    logic                       clk, arst_n, slow_clk;
    apb_req_t                   apb_req;
    apb_rsp_t                   apb_rsp;
    logic [`SOC_GPIO_NUM-1:0]   gpio_in, gpio_out, gpio_dir;
    logic [5:0]                 periph_evt;          // sources 5:0
    logic [`SOC_FC_EVT_NUM-1:0] fc_events;
    logic                       fc_valid, fc_ready;
    logic [`SOC_EVNT_W-1:0]     fc_data;

    int                         errors = 0;
    int                         checks = 0;
    int                         cycles = 0;
    int                         cycle_limit = 0;     // set from the trace before reset ends
    int                         pulse_cnt [`SOC_FC_EVT_NUM];
    logic [`SOC_EVNT_W-1:0]     pops [$];            // ids taken by the fc, oldest first

    soc_periph_top u_dut (
        .clk_i            ( clk        ),
        .arst_n_i         ( arst_n     ),
        .slow_clk_i       ( slow_clk   ),
        .apb_req_i        ( apb_req    ),
        .apb_rsp_o        ( apb_rsp    ),
        .gpio_in_i        ( gpio_in    ),
        .gpio_out_o       ( gpio_out   ),
        .gpio_dir_o       ( gpio_dir   ),
        .periph_evt_i     ( periph_evt ),
        .fc_events_o      ( fc_events  ),
        .fc_event_valid_o ( fc_valid   ),
        .fc_event_data_o  ( fc_data    ),
        .fc_event_ready_i ( fc_ready   )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        slow_clk = 1'b0;
        forever #40 slow_clk = ~slow_clk;   // 8 fast cycles per period
    end

    //////////////////////////////////////////////////////////////////////
    // monitor and cycle limit
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        for (int b = 0; b < `SOC_FC_EVT_NUM; b++) begin
            if (fc_events[b]) pulse_cnt[b] += 1;   // pulses are one cycle wide
        end
        if ((fc_events & ~FC_USED_BITS) != '0) begin
            compare_value("fc_events_o reserved bits", 32'd0, fc_events & ~FC_USED_BITS);
        end
        if (fc_valid && fc_ready) pops.push_back(fc_data);
    end

    always @(posedge clk) begin
        cycles += 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the trace did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        checks += 1;
        if (act_val !== exp_val) begin
            errors += 1;
            $display("error at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic apb_write(input logic [`SOC_APB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb_req.psel   = 1'b1;                   // setup
        apb_req.pwrite = 1'b1;
        apb_req.paddr  = addr;
        apb_req.pwdata = data;
        @(negedge clk);
        apb_req.penable = 1'b1;                  // access, lands at next rising edge
        @(negedge clk);
        apb_req = '0;
        // pins follow one cycle after the access cycle
        if (addr == GPIO_OUT_ADDR) compare_value("gpio_out_o", 32'(data[7:0]), 32'(gpio_out));
        if (addr == GPIO_DIR_ADDR) compare_value("gpio_dir_o", 32'(data[7:0]), 32'(gpio_dir));
    endtask

    task automatic apb_read(input logic [`SOC_APB_ADDR_W-1:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        @(negedge clk);
        apb_req.psel   = 1'b1;
        apb_req.pwrite = 1'b0;
        apb_req.paddr  = addr;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;                                      // read data is combinational
        compare_value($sformatf("prdata at %h", addr), exp_data, apb_rsp.prdata);
        compare_value($sformatf("pslverr at %h", addr), 32'(exp_err), 32'(apb_rsp.pslverr));
        compare_value("pready", 32'd1, 32'(apb_rsp.pready));
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic pulse_events(input logic [5:0] evts);
        @(negedge clk);
        periph_evt = evts;
        @(negedge clk);
        periph_evt = '0;
    endtask

    task automatic check_pops(input logic [`SOC_EVNT_W-1:0] exp_id);
        while (pops.size() == 0) @(negedge clk);
        compare_value("fc_event_data_o", 32'(exp_id), 32'(pops.pop_front()));
    endtask

    // tol 0 compares exactly, otherwise exp +- tol passes
    task automatic check_pulses(input int bit_idx, input int exp_cnt, input int tol);
        int cnt;
        logic in_range;
        cnt      = pulse_cnt[bit_idx];
        in_range = (cnt >= exp_cnt - tol) && (cnt <= exp_cnt + tol);
        if (tol == 0) begin
            compare_value($sformatf("fc_events_o[%0d] pulses", bit_idx), exp_cnt, cnt);
        end else begin
            compare_value($sformatf("fc_events_o[%0d] pulses %0d within %0d+-%0d",
                                    bit_idx, cnt, exp_cnt, tol), 32'd1, 32'(in_range));
        end
    endtask

    // next opcode char and its hex fields, op -1 at end of file
    task automatic read_op(input int fd, output int op, output logic [31:0] a, b, c);
        int ch;
        int n;
        int need;
        a    = '0;
        b    = '0;
        c    = '0;
        n    = 0;
        need = 0;
        op   = -1;
        ch   = $fgetc(fd);
        while (ch == "#" || ch == " " || ch == "\n" || ch == "\r" || ch == "\t") begin
            if (ch == "#") begin
                while (ch != "\n" && ch != -1) ch = $fgetc(fd);   // comment line
            end
            ch = $fgetc(fd);
        end
        if (ch != -1) begin
            op = ch;
            case (ch)
                "W": begin
                    need = 2;
                    n    = $fscanf(fd, "%h %h", a, b);
                end
                "R", "N": begin
                    need = 3;
                    n    = $fscanf(fd, "%h %h %h", a, b, c);
                end
                "G", "E", "Q", "P", "C": begin
                    need = 1;
                    n    = $fscanf(fd, "%h", a);
                end
                default: ;
            endcase
            if (n != need) begin
                errors += 1;
                $display("trace line for op %c is missing fields", ch[7:0]);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // trace replay
    //////////////////////////////////////////////////////////////////////
    initial begin
        int          fd;
        int          op;
        int          total_c;
        int          n_ops;
        logic [31:0] a, b, c;
        apb_req    = '0;
        gpio_in    = '0;
        periph_evt = '0;
        fc_ready   = 1'b0;
        arst_n     = 1'b0;
        total_c    = 0;
        n_ops      = 0;
        fd = $fopen("soc_periph_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open soc_periph_trace.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            read_op(fd, op, a, b, c);            // first pass sizes the cycle limit
            while (op != -1) begin
                n_ops += 1;
                if (op == "C") total_c += int'(a);
                read_op(fd, op, a, b, c);
            end
            cycle_limit = total_c + 12 * n_ops + 200;
            $fclose(fd);
            fd = $fopen("soc_periph_trace.txt", "r");
            repeat (5) @(negedge clk);
            arst_n = 1'b1;
            // idle state straight out of reset
            compare_value("fc_event_valid_o", 32'd0, 32'(fc_valid));
            compare_value("gpio_dir_o", 32'd0, 32'(gpio_dir));
            compare_value("gpio_out_o", 32'd0, 32'(gpio_out));
            read_op(fd, op, a, b, c);
            while (op != -1) begin
                case (op)
                    "W": apb_write(a[`SOC_APB_ADDR_W-1:0], b);
                    "R": apb_read(a[`SOC_APB_ADDR_W-1:0], b, c[0]);
                    "G": begin
                        @(negedge clk);
                        gpio_in = a[`SOC_GPIO_NUM-1:0];
                    end
                    "E": pulse_events(a[5:0]);
                    "Q": begin
                        @(negedge clk);
                        fc_ready = a[0];
                    end
                    "P": check_pops(a[`SOC_EVNT_W-1:0]);
                    "N": check_pulses(int'(a), int'(b), int'(c));
                    "Z": foreach (pulse_cnt[i]) pulse_cnt[i] = 0;   // new counting window
                    "C": repeat (int'(a)) @(negedge clk);
                    default: begin
                        errors += 1;
                        $display("unknown opcode %c in the trace", op[7:0]);
                    end
                endcase
                read_op(fd, op, a, b, c);
            end
            $fclose(fd);
            repeat (4) @(negedge clk);           // catch late stray pops
            if (pops.size() != 0) begin
                errors += 1;
                $display("%0d event ids were popped that the trace did not expect", pops.size());
            end
            $display("checks %0d errors %0d", checks, errors);
            if (errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule
